/* logic/scr_ram_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Sizes, S-box tables and request structs for the scrambled SRAM.
// Depth must stay a power of two so that the address map remains bijective.
////////////////////////////////////////////////////////////////////////////

package scr_ram_pkg;

  // Memory geometry
  localparam int DataWidth      = 32;
  localparam int Depth          = 1024;
  localparam int AddrWidth      = 10;

  // Keystream cipher, the IV is {nonce bits, plain address}
  localparam int KsWidth        = 64;
  localparam int KeyWidth       = 64;
  localparam int NonceWidth     = 64;
  localparam int DataNonceWidth = KsWidth - AddrWidth;

  // Diffusion works on byte slices so that byte masks keep working
  localparam int ByteWidth      = 8;
  localparam int NumBytes       = DataWidth / ByteWidth;

  // Round counts, the keystream register sits after NumKsRounds / 2
  localparam int NumKsRounds    = 4;
  localparam int NumDiffRounds  = 2;
  localparam int NumAddrRounds  = 2;

  // Entry i of the table sits at bits [4*i +: 4]
  localparam logic [63:0] SBox4    = 64'h4D5E_0876_19CA_23FB;
  localparam logic [63:0] SBox4Inv = 64'h1CE5_046A_98DF_237B;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [ByteWidth-1:0] byte_t;

  // Request towards the memory macro, wmask is a bit mask
  typedef struct packed {
    logic  req;
    logic  write;
    addr_t addr;
    data_t wdata;
    data_t wmask;
  } mem_req_t;

  // Host operation as seen in its grant cycle
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    data_t wmask;
  } host_req_t;

endpackage

/* logic/subst_perm.sv */
////////////////////////////////////////////////////////////////////////////
// Keyed substitution/permutation network, purely combinational.
// Bits above the last full nibble bypass the S-box but do get permuted.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module subst_perm #(
  parameter type data_t    = logic [7:0],
  parameter int  NumRounds = 2,
  parameter bit  Decrypt   = 1'b0
) (
  input  data_t data_i,
  input  data_t key_i,
  output data_t data_o
);

  localparam int Width      = $bits(data_t);
  localparam int NumNibbles = Width / 4;

  always_comb begin : p_rounds
    logic [Width-1:0] state;
    logic [Width-1:0] rev;
    state = data_i;
    rev   = '0;
    for (int r = 0; r < NumRounds; r++) begin
      if (!Decrypt) begin
        // Forward round: key, substitution, then bit reversal
        state = state ^ key_i;
        for (int n = 0; n < NumNibbles; n++) begin
          state[4*n +: 4] = scr_ram_pkg::SBox4[4 * state[4*n +: 4] +: 4];
        end
        for (int b = 0; b < Width; b++) begin
          rev[b] = state[Width-1-b];
        end
        state = rev;
      end else begin
        // Inverse round, the reversal is its own inverse
        for (int b = 0; b < Width; b++) begin
          rev[b] = state[Width-1-b];
        end
        state = rev;
        for (int n = 0; n < NumNibbles; n++) begin
          state[4*n +: 4] = scr_ram_pkg::SBox4Inv[4 * state[4*n +: 4] +: 4];
        end
        state = state ^ key_i;
      end
    end
    data_o = state;
  end

endmodule

/* logic/keystream_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Reduced-round block cipher used in counter mode, one cycle of latency.
// The key is assumed static while requests are granted.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module keystream_gen (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 valid_i,
  input  logic [scr_ram_pkg::KeyWidth-1:0]     key_i,
  input  logic [scr_ram_pkg::KsWidth-1:0]      iv_i,
  output logic [scr_ram_pkg::KsWidth-1:0]      keystream_o
);

  // One round: rotated key, S-box on all nibbles, fixed bit scatter
  function automatic logic [63:0] ks_round(logic [63:0] state_in, logic [63:0] key, int rnd);
    logic [63:0] s;
    logic [63:0] p;
    s = state_in ^ ((key << rnd) | (key >> (64 - rnd)));
    for (int n = 0; n < 16; n++) begin
      s[4*n +: 4] = scr_ram_pkg::SBox4[4 * s[4*n +: 4] +: 4];
    end
    // 13 is odd so this index map is a permutation of the 64 bits
    for (int i = 0; i < 64; i++) begin
      p[(i * 13) % 64] = s[i];
    end
    return p;
  endfunction

  logic [scr_ram_pkg::KsWidth-1:0] mid_d;
  logic [scr_ram_pkg::KsWidth-1:0] mid_q;

  // First half runs in the grant cycle
  always_comb begin : p_first_half
    logic [63:0] st;
    st = iv_i;
    for (int r = 0; r < scr_ram_pkg::NumKsRounds / 2; r++) begin
      st = ks_round(st, key_i, r);
    end
    mid_d = st;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mid_q <= '0;
    end else if (valid_i) begin
      mid_q <= mid_d;
    end
  end

  // Second half runs from the register, so the keystream is ready one cycle later
  always_comb begin : p_second_half
    logic [63:0] st;
    st = mid_q;
    for (int r = scr_ram_pkg::NumKsRounds / 2; r < scr_ram_pkg::NumKsRounds; r++) begin
      st = ks_round(st, key_i, r);
    end
    keystream_o = st;
  end

  // A delayed write reuses the keystream of its grant, so it must survive idle cycles
  a_mid_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !valid_i |=> $stable(mid_q));

endmodule

/* logic/data_scrambler.sv */
////////////////////////////////////////////////////////////////////////////
// Keystream XOR plus per-byte diffusion, combinational in both directions.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module data_scrambler (
  input  scr_ram_pkg::data_t wdata_i,
  input  scr_ram_pkg::data_t keystream_i,
  input  scr_ram_pkg::data_t rdata_scr_i,
  output scr_ram_pkg::data_t wdata_scr_o,
  output scr_ram_pkg::data_t rdata_o
);

  scr_ram_pkg::data_t wdata_xor;
  scr_ram_pkg::data_t rdata_xor;

  // Write side applies the keystream first
  assign wdata_xor = wdata_i ^ keystream_i;

  // Diffusion stays inside a byte so partial writes still line up with the mask
  for (genvar k = 0; k < scr_ram_pkg::NumBytes; k++) begin : gen_byte
    subst_perm #(
      .data_t    (scr_ram_pkg::byte_t),
      .NumRounds (scr_ram_pkg::NumDiffRounds),
      .Decrypt   (1'b0)
    ) u_enc (
      .data_i (wdata_xor[k*scr_ram_pkg::ByteWidth +: scr_ram_pkg::ByteWidth]),
      .key_i  ('0),
      .data_o (wdata_scr_o[k*scr_ram_pkg::ByteWidth +: scr_ram_pkg::ByteWidth])
    );

    subst_perm #(
      .data_t    (scr_ram_pkg::byte_t),
      .NumRounds (scr_ram_pkg::NumDiffRounds),
      .Decrypt   (1'b1)
    ) u_dec (
      .data_i (rdata_scr_i[k*scr_ram_pkg::ByteWidth +: scr_ram_pkg::ByteWidth]),
      .key_i  ('0),
      .data_o (rdata_xor[k*scr_ram_pkg::ByteWidth +: scr_ram_pkg::ByteWidth])
    );
  end

  // Read side ends with the keystream, which hides the cipher delay behind the macro
  assign rdata_o = rdata_xor ^ keystream_i;

endmodule

/* logic/pending_write_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Grant, one-cycle delayed writes and the pending write slot.
// Holds a single pending write, which is enough because a write grant never has a read.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pending_write_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  key_valid_i,
  input  scr_ram_pkg::host_req_t host_i,
  input  scr_ram_pkg::addr_t    addr_scr_i,
  input  scr_ram_pkg::data_t    wdata_scr_i,
  input  scr_ram_pkg::data_t    rdata_plain_i,
  output logic                  gnt_o,
  output scr_ram_pkg::data_t    wdata_o,
  output scr_ram_pkg::mem_req_t mem_o,
  output scr_ram_pkg::data_t    rdata_o,
  output logic                  rvalid_o
);

  logic               read_en;
  logic               write_en_d;
  logic               write_en_q;
  logic               write_pending_d;
  logic               write_pending_q;
  logic               rw_collision;
  logic               mem_write;
  logic               addr_collision_d;
  logic               addr_collision_q;
  logic               rvalid_q;
  scr_ram_pkg::addr_t waddr_scr_q;
  scr_ram_pkg::data_t wmask_q;
  scr_ram_pkg::data_t wdata_q;
  scr_ram_pkg::data_t wdata_scr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Strobes

  // Without a valid key nothing is granted and the host retries
  assign gnt_o      = req_i & key_valid_i;
  assign read_en    = gnt_o & ~host_i.write;
  assign write_en_d = gnt_o & host_i.write;

  // A delayed or pending write may only use the macro when no read arrives
  assign mem_write    = (write_en_q | write_pending_q) & ~read_en;
  assign rw_collision = write_en_q & read_en;

  // Set when a fresh write loses to a read, cleared once it reaches the macro
  assign write_pending_d = mem_write    ? 1'b0 :
                           rw_collision ? 1'b1 :
                                          write_pending_q;

  // Read hitting the address of the write that has not landed yet
  assign addr_collision_d = read_en & (write_en_q | write_pending_q) &
                            (addr_scr_i == waddr_scr_q);

  ////////////////////////////////////////////////////////////////////////////
  // Memory request

  assign mem_o.req   = read_en | write_en_q | write_pending_q;
  assign mem_o.write = mem_write;
  assign mem_o.addr  = read_en ? addr_scr_i : waddr_scr_q;
  // The keystream has moved on once a read was granted, so use the saved copy
  assign mem_o.wdata = write_pending_q ? wdata_scr_q : wdata_scr_i;
  assign mem_o.wmask = wmask_q;

  assign wdata_o = wdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read response

  // Masked bits of the latest write override what the macro returned
  assign rdata_o  = addr_collision_q ? ((wdata_q & wmask_q) | (rdata_plain_i & ~wmask_q)) :
                                       rdata_plain_i;
  assign rvalid_o = rvalid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_en_q       <= 1'b0;
      write_pending_q  <= 1'b0;
      addr_collision_q <= 1'b0;
      rvalid_q         <= 1'b0;
    end else begin
      write_en_q       <= write_en_d;
      write_pending_q  <= write_pending_d;
      addr_collision_q <= addr_collision_d;
      rvalid_q         <= read_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_en_d) begin
      waddr_scr_q <= addr_scr_i;
      wmask_q     <= host_i.wmask;
      wdata_q     <= host_i.wdata;
    end
    if (rw_collision) begin
      wdata_scr_q <= wdata_scr_i;
    end
  end

  a_no_write_on_read : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_o && !host_i.write) |-> !(mem_o.req && mem_o.write));

  a_rvalid_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    1'b1 |=> (rvalid_o == $past(gnt_o && !host_i.write)));

endmodule

/* logic/sram_array.sv */
////////////////////////////////////////////////////////////////////////////
// Behavioral single-port macro, contents are undefined after power-up.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_array (
  input  logic                  clk_i,
  input  scr_ram_pkg::mem_req_t mem_i,
  output scr_ram_pkg::data_t    rdata_o
);

  scr_ram_pkg::data_t mem [scr_ram_pkg::Depth];
  scr_ram_pkg::data_t rdata_q;

  // Writes touch only the bits set in the mask
  always_ff @(posedge clk_i) begin
    if (mem_i.req && mem_i.write) begin
      mem[mem_i.addr] <= (mem[mem_i.addr] & ~mem_i.wmask) | (mem_i.wdata & mem_i.wmask);
    end
  end

  // Read data is held until the next read
  always_ff @(posedge clk_i) begin
    if (mem_i.req && !mem_i.write) begin
      rdata_q <= mem[mem_i.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* logic/scr_ram_top.sv */
////////////////////////////////////////////////////////////////////////////
// Scrambled single-port SRAM, reads answer one cycle after grant.
// Nonce bits feed both the address key and the IV, so change them only when idle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scr_ram_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 key_valid_i,
  input  logic [scr_ram_pkg::KeyWidth-1:0]     key_i,
  input  logic [scr_ram_pkg::NonceWidth-1:0]   nonce_i,
  input  logic                                 req_i,
  output logic                                 gnt_o,
  input  logic                                 write_i,
  input  scr_ram_pkg::addr_t                   addr_i,
  input  scr_ram_pkg::data_t                   wdata_i,
  input  scr_ram_pkg::data_t                   wmask_i,
  output scr_ram_pkg::data_t                   rdata_o,
  output logic                                 rvalid_o
);

  scr_ram_pkg::host_req_t          host_req;
  scr_ram_pkg::addr_t              addr_key;
  scr_ram_pkg::addr_t              addr_scr;
  logic [scr_ram_pkg::KsWidth-1:0] keystream;
  scr_ram_pkg::data_t              wdata_q;
  scr_ram_pkg::data_t              wdata_scr;
  scr_ram_pkg::data_t              rdata_scr;
  scr_ram_pkg::data_t              rdata_plain;
  scr_ram_pkg::mem_req_t           mem_req;

  assign host_req = '{write: write_i, addr: addr_i, wdata: wdata_i, wmask: wmask_i};

  // The top nonce bits are not part of the IV and serve as address key
  assign addr_key = nonce_i[scr_ram_pkg::NonceWidth-scr_ram_pkg::AddrWidth +:
                            scr_ram_pkg::AddrWidth];

  subst_perm #(
    .data_t    (scr_ram_pkg::addr_t),
    .NumRounds (scr_ram_pkg::NumAddrRounds),
    .Decrypt   (1'b0)
  ) u_addr_scr (
    .data_i (host_req.addr),
    .key_i  (addr_key),
    .data_o (addr_scr)
  );

  // IV uses the plain address, so equal words at different rows still differ
  keystream_gen u_keystream (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (gnt_o),
    .key_i       (key_i),
    .iv_i        ({nonce_i[scr_ram_pkg::DataNonceWidth-1:0], host_req.addr}),
    .keystream_o (keystream)
  );

  // Only the low word of the keystream is used
  data_scrambler u_data_scr (
    .wdata_i     (wdata_q),
    .keystream_i (keystream[scr_ram_pkg::DataWidth-1:0]),
    .rdata_scr_i (rdata_scr),
    .wdata_scr_o (wdata_scr),
    .rdata_o     (rdata_plain)
  );

  pending_write_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .key_valid_i   (key_valid_i),
    .host_i        (host_req),
    .addr_scr_i    (addr_scr),
    .wdata_scr_i   (wdata_scr),
    .rdata_plain_i (rdata_plain),
    .gnt_o         (gnt_o),
    .wdata_o       (wdata_q),
    .mem_o         (mem_req),
    .rdata_o       (rdata_o),
    .rvalid_o      (rvalid_o)
  );

  sram_array u_sram (
    .clk_i   (clk_i),
    .mem_i   (mem_req),
    .rdata_o (rdata_scr)
  );

endmodule

/* test/tb_scr_ram.sv */
////////////////////////////////////////////////////////////////////////////
// Random and directed traffic inside a 16-word window against a reference
// memory. Key and nonce stay fixed, so every window word is written first.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_scr_ram;

  localparam int ClkPeriod    = 40;
  localparam int DriveDelay   = 2;
  localparam int ResetCycles  = 2;
  localparam int IdleCycles   = 3;
  localparam int WindowSize   = 16;
  localparam int NumPatterns  = 4;
  localparam int PatternLen   = 17;
  localparam int NumRandomOps = 400;
  localparam int BurstEvery   = 100;
  localparam int BurstLen     = 12;
  localparam int DrainCycles  = 2;
  localparam int MarginCycles = 50;

  // Fill, two window reads, patterns, random ops and the key-invalid bursts
  localparam int TestCycles = ResetCycles + IdleCycles + 3 * WindowSize +
                              NumPatterns * PatternLen + NumRandomOps +
                              (NumRandomOps / BurstEvery) * BurstLen + DrainCycles;
  localparam int TimeoutNs  = (TestCycles + MarginCycles) * ClkPeriod;

  // The window crosses a row boundary on purpose
  localparam scr_ram_pkg::addr_t WindowBase = 10'h1f8;
  localparam scr_ram_pkg::data_t FullMask   = 32'hffff_ffff;

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni;
  logic                                 key_valid_i;
  logic [scr_ram_pkg::KeyWidth-1:0]     key_i;
  logic [scr_ram_pkg::NonceWidth-1:0]   nonce_i;
  logic                                 req_i;
  logic                                 gnt_o;
  logic                                 write_i;
  scr_ram_pkg::addr_t                   addr_i;
  scr_ram_pkg::data_t                   wdata_i;
  scr_ram_pkg::data_t                   wmask_i;
  scr_ram_pkg::data_t                   rdata_o;
  logic                                 rvalid_o;

  // Reference memory and the values owed to granted reads
  scr_ram_pkg::data_t ref_mem [scr_ram_pkg::Depth];
  scr_ram_pkg::data_t expected_q [$];
  logic               read_prev;
  logic [31:0]        rng_state;

  scr_ram_top uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_valid_i (key_valid_i),
    .key_i       (key_i),
    .nonce_i     (nonce_i),
    .req_i       (req_i),
    .gnt_o       (gnt_o),
    .write_i     (write_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .wmask_i     (wmask_i),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Failure handling and random numbers

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Mismatch at %t: %s expected %0h, actual %0h", $time, name, expected, actual);
    abort_run();
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_random(output logic [31:0] value);
    rng_state = lcg_next(rng_state);
    value     = rng_state;
  endtask

  // One select bit per byte lane
  function automatic scr_ram_pkg::data_t byte_mask(input logic [3:0] sel);
    scr_ram_pkg::data_t m;
    for (int k = 0; k < scr_ram_pkg::NumBytes; k++) begin
      m[k*scr_ram_pkg::ByteWidth +: scr_ram_pkg::ByteWidth] = {scr_ram_pkg::ByteWidth{sel[k]}};
    end
    return m;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks that each last one clock and end just after a rising edge

  task automatic drive_op(input logic req, input logic wr, input scr_ram_pkg::addr_t addr,
                          input scr_ram_pkg::data_t data, input scr_ram_pkg::data_t mask);
    req_i   = req;
    write_i = wr;
    addr_i  = addr;
    wdata_i = data;
    wmask_i = mask;
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic drive_idle();
    drive_op(1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic write_word(input scr_ram_pkg::addr_t addr, input scr_ram_pkg::data_t mask);
    logic [31:0] data;
    draw_random(data);
    drive_op(1'b1, 1'b1, addr, data, mask);
  endtask

  task automatic read_word(input scr_ram_pkg::addr_t addr);
    drive_op(1'b1, 1'b0, addr, '0, '0);
  endtask

  task automatic fill_window();
    for (int i = 0; i < WindowSize; i++) begin
      write_word(WindowBase + scr_ram_pkg::addr_t'(i), FullMask);
    end
  endtask

  // Back-to-back reads where the first one may collide with a delayed write
  task automatic read_window();
    for (int i = 0; i < WindowSize; i++) begin
      read_word(WindowBase + scr_ram_pkg::addr_t'(i));
    end
  endtask

  // Delayed, pending and forwarded writes in a fixed order of PatternLen cycles
  task automatic collision_patterns();
    scr_ram_pkg::addr_t a;
    scr_ram_pkg::addr_t b;
    scr_ram_pkg::addr_t c;
    for (int i = 0; i < NumPatterns; i++) begin
      a = WindowBase + scr_ram_pkg::addr_t'(i);
      b = WindowBase + scr_ram_pkg::addr_t'(i + 4);
      c = WindowBase + scr_ram_pkg::addr_t'(i + 8);
      write_word(a, FullMask);
      read_word(a);
      read_word(b);
      write_word(c, 32'h00ff_ff00);
      read_word(a);
      // Hits the pending write to c so only its middle bytes are forwarded
      read_word(c);
      write_word(b, 32'hff00_00ff);
      write_word(a, 32'h0000_ffff);
      read_word(a);
      read_word(a);
      drive_idle();
      read_word(a);
      write_word(b, FullMask);
      write_word(c, FullMask);
      read_word(b);
      read_word(c);
      drive_idle();
    end
  endtask

  task automatic random_op();
    logic [31:0]        r;
    scr_ram_pkg::addr_t addr;
    draw_random(r);
    addr = WindowBase + scr_ram_pkg::addr_t'(r[27:24]);
    if (r[31:29] < 3'd3) begin
      read_word(addr);
    end else if (r[31:29] < 3'd7) begin
      write_word(addr, byte_mask(r[23:20]));
    end else begin
      drive_idle();
    end
  endtask

  // Requests keep coming but none may be granted
  task automatic invalid_key_burst();
    key_valid_i = 1'b0;
    for (int i = 0; i < BurstLen; i++) begin
      random_op();
    end
    key_valid_i = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks run on the falling edge where all outputs are settled

  always @(negedge clk_i) begin : check_outputs
    logic               exp_gnt;
    scr_ram_pkg::data_t exp_rdata;
    exp_gnt = req_i && key_valid_i;
    a_gnt : assert (gnt_o === exp_gnt)
      else report_mismatch("gnt_o", 32'(exp_gnt), 32'(gnt_o));
    a_rvalid : assert (rvalid_o === read_prev)
      else report_mismatch("rvalid_o", 32'(read_prev), 32'(rvalid_o));
    if (read_prev) begin
      exp_rdata = expected_q.pop_front();
      a_rdata : assert (rdata_o === exp_rdata)
        else report_mismatch("rdata_o", exp_rdata, rdata_o);
    end
    read_prev = 1'b0;
    // The model is updated in grant order so a read sees every earlier write
    if (rst_ni && exp_gnt) begin
      if (write_i) begin
        ref_mem[addr_i] = (ref_mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
      end else begin
        expected_q.push_back(ref_mem[addr_i]);
        read_prev = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("Watchdog expired after %0d ns, the test sequence did not finish", TimeoutNs);
    abort_run();
  end

  initial begin : main_sequence
    $timeformat(-9, 1, " ns", 10);
    rng_state   = 32'h7056_24d1;
    read_prev   = 1'b0;
    rst_ni      = 1'b0;
    key_valid_i = 1'b1;
    key_i       = 64'h3c5a_9e17_d204_b86f;
    nonce_i     = 64'h9b21_6e4c_07f3_a5d8;
    req_i       = 1'b0;
    write_i     = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    wmask_i     = '0;

    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    repeat (IdleCycles) drive_idle();
    fill_window();
    read_window();
    collision_patterns();
    for (int n = 0; n < NumRandomOps; n++) begin
      if (n % BurstEvery == 0) begin
        invalid_key_burst();
      end
      random_op();
    end
    read_window();
    repeat (DrainCycles) drive_idle();

    $display("Simulation passed");
    $finish;
  end

endmodule

/* flist.f */
logic/scr_ram_pkg.sv
logic/subst_perm.sv
logic/keystream_gen.sv
logic/data_scrambler.sv
logic/pending_write_ctrl.sv
logic/sram_array.sv
logic/scr_ram_top.sv
test/tb_scr_ram.sv

/* Makefile */
# Verilator build and run for the scrambled SRAM testbench
VERILATOR ?= verilator
TOP       ?= tb_scr_ram
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0

SRCS := $(wildcard logic/*.sv test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
